// File: cpu_pkg.sv
package cpu_pkg;

    localparam int addr_bits = 8;
    localparam int data_bits = 8;
    localparam int reg_addr_bits = 4;

    // Fixed entry point of the interrupt service routine
    localparam logic [addr_bits-1:0] isr_address = 8'he0;

    // Top four bits of the instruction high byte
    typedef enum logic [3:0] {
        MOVIR      = 4'h0,
        RESERVED_A = 4'h1,
        LOAD       = 4'h2,
        STORE      = 4'h3,
        ADDRR      = 4'h4,
        ADDI       = 4'h5,
        SUBRR      = 4'h6,
        SUBI       = 4'h7,
        JNZI       = 4'h8,
        JZR        = 4'h9,
        JMP        = 4'ha,
        CLI        = 4'hb,
        STI        = 4'hc,
        RETI       = 4'hd,
        RESERVED_B = 4'he,
        NOP        = 4'hf
    } opcode_t;

    typedef enum logic [2:0] {
        FETCH_START,
        FETCH_HI,
        FETCH_LO,
        EXECUTE,
        WRITEBACK,
        STORE_STAGE
    } exec_stage_t;

    typedef enum logic [2:0] {
        HOLD,
        NEXT_INSTR,
        JUMP_TARGET,
        ISR_TARGET,
        ISR_RETURN
    } pc_sel_t;

endpackage

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic [cpu_pkg::data_bits-1:0] a,
    input  logic [cpu_pkg::data_bits-1:0] b,
    input  logic                         subtract,
    input  logic                         flag_we,
    output logic [cpu_pkg::data_bits-1:0] result,
    output logic                         zero_flag,
    output logic                         carry_flag
);
    import cpu_pkg::*;

    logic [data_bits:0]   sum;
    logic [data_bits-1:0] b_operand;

    // Subtract as a + ~b + 1, so carry out means no borrow
    assign b_operand = subtract ? ~b : b;
    assign sum = {1'b0, a} + {1'b0, b_operand} + {{data_bits{1'b0}}, subtract};
    assign result = sum[data_bits-1:0];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            zero_flag  <= 1'b0;
            carry_flag <= 1'b0;
        end else if (flag_we) begin
            zero_flag  <= (result == '0);
            carry_flag <= sum[data_bits];
        end
    end

    flag_we_known: assert property (
        @(posedge clk) disable iff (!reset_n) !$isunknown(flag_we)
    );

endmodule

// File: register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic [cpu_pkg::reg_addr_bits-1:0] rd0_addr,
    input  logic [cpu_pkg::reg_addr_bits-1:0] rd1_addr,
    input  logic                             wr_en,
    input  logic [cpu_pkg::reg_addr_bits-1:0] wr_addr,
    input  logic [cpu_pkg::data_bits-1:0]     wr_data,
    output logic [cpu_pkg::data_bits-1:0]     rd0_data,
    output logic [cpu_pkg::data_bits-1:0]     rd1_data
);
    import cpu_pkg::*;

    logic [data_bits-1:0] regs [2**reg_addr_bits];

    // Both read ports are combinational
    assign rd0_data = regs[rd0_addr];
    assign rd1_data = regs[rd1_addr];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < 2**reg_addr_bits; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    wr_addr_known: assert property (
        @(posedge clk) disable iff (!reset_n) wr_en |-> !$isunknown(wr_addr)
    );

endmodule

// File: pc_sequencer.sv
`timescale 1ns/1ps

module pc_sequencer (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         boundary,
    input  cpu_pkg::pc_sel_t             pc_sel,
    input  logic [cpu_pkg::addr_bits-1:0] jump_target,
    input  logic                         int_req,
    input  logic                         int_enable_set,
    input  logic                         int_enable_clear,
    output logic [cpu_pkg::addr_bits-1:0] pc,
    output logic                         take_interrupt,
    output logic                         int_ack
);
    import cpu_pkg::*;

    logic [addr_bits-1:0] saved_pc;
    logic [addr_bits-1:0] next_pc;
    logic                 int_req_q;
    logic                 int_pending;
    logic                 int_enabled;
    pc_sel_t              sel;

    // Interrupt only redirects at an instruction boundary
    assign take_interrupt = boundary && int_pending && int_enabled;
    assign int_ack = take_interrupt;
    assign sel = take_interrupt ? ISR_TARGET : pc_sel;

    always_comb begin
        case (sel)
            NEXT_INSTR:  next_pc = pc + addr_bits'(2);
            JUMP_TARGET: next_pc = jump_target;
            ISR_TARGET:  next_pc = isr_address;
            ISR_RETURN:  next_pc = saved_pc;
            default:     next_pc = pc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc          <= '0;
            int_req_q   <= 1'b0;
            int_pending <= 1'b0;
            int_enabled <= 1'b0;
        end else begin
            pc        <= next_pc;
            int_req_q <= int_req;
            if (take_interrupt) begin
                int_pending <= 1'b0;
            end else if (int_req && !int_req_q && int_enabled) begin
                int_pending <= 1'b1;
            end
            if (take_interrupt || int_enable_clear) begin
                int_enabled <= 1'b0;
            end else if (int_enable_set) begin
                int_enabled <= 1'b1;
            end
        end
    end

    // pc already points at the next instruction here
    always_ff @(posedge clk) begin
        if (take_interrupt) begin
            saved_pc <= pc;
        end
    end

    int_ack_single: assert property (
        @(posedge clk) disable iff (!reset_n) int_ack |=> !int_ack
    );

endmodule

// File: exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
    input  logic                         clk,
    input  logic                         reset_n,
    output logic                         rd_en,
    output logic [cpu_pkg::addr_bits-1:0] rd_addr,
    input  logic [cpu_pkg::data_bits-1:0] rd_data,
    output logic                         wr_en,
    output logic [cpu_pkg::addr_bits-1:0] wr_addr,
    output logic [cpu_pkg::data_bits-1:0] wr_data,
    input  logic                         int_req,
    output logic                         int_ack
);
    import cpu_pkg::*;

    exec_stage_t              stage;
    logic [2*data_bits-1:0]   ir;
    opcode_t                  opcode;
    logic                     is_arith;
    logic [reg_addr_bits-1:0] rd0_addr;
    logic [reg_addr_bits-1:0] rd1_addr;
    logic [data_bits-1:0]     rd0_data;
    logic [data_bits-1:0]     rd1_data;
    logic [data_bits-1:0]     alu_b;
    logic [data_bits-1:0]     alu_result;
    logic                     subtract;
    logic                     flag_we;
    logic                     zero_flag;
    logic                     rf_wr_en;
    logic [data_bits-1:0]     rf_wr_data;
    logic                     boundary;
    pc_sel_t                  pc_sel;
    logic [addr_bits-1:0]     pc;
    logic                     take_interrupt;
    logic                     int_enable_set;
    logic                     int_enable_clear;

    assign opcode = opcode_t'(ir[15:12]);
    assign is_arith = (opcode == ADDRR) || (opcode == ADDI) ||
                      (opcode == SUBRR) || (opcode == SUBI);

    assign subtract = (opcode == SUBRR) || (opcode == SUBI);
    assign alu_b = ((opcode == ADDI) || (opcode == SUBI)) ? ir[7:0] : rd1_data;
    assign flag_we = (stage == EXECUTE) && is_arith;

    assign boundary = (stage == FETCH_START);
    assign int_enable_set = (stage == EXECUTE) && ((opcode == STI) || (opcode == RETI));
    assign int_enable_clear = (stage == EXECUTE) && (opcode == CLI);

    // Memory read requests with data back one cycle later
    always_comb begin
        rd_en = 1'b0;
        rd_addr = pc;
        case (stage)
            FETCH_START: begin
                rd_en = 1'b1;
                rd_addr = take_interrupt ? isr_address : pc;
            end
            FETCH_HI: begin
                rd_en = 1'b1;
                rd_addr = pc + addr_bits'(1);
            end
            EXECUTE: begin
                if (opcode == LOAD) begin
                    rd_en = 1'b1;
                    rd_addr = ir[7:0];
                end
            end
            default: begin
                rd_en = 1'b0;
            end
        endcase
    end

    // Next pc is decided once the low byte has arrived
    always_comb begin
        pc_sel = HOLD;
        if (stage == FETCH_LO) begin
            if (opcode == JNZI && !zero_flag) begin
                pc_sel = JUMP_TARGET;
            end else if (opcode == RETI) begin
                pc_sel = ISR_RETURN;
            end else begin
                pc_sel = NEXT_INSTR;
            end
        end
    end

    always_comb begin
        rf_wr_en = 1'b0;
        rf_wr_data = alu_result;
        if (stage == EXECUTE && opcode == MOVIR) begin
            rf_wr_en = 1'b1;
            rf_wr_data = ir[7:0];
        end else if (stage == WRITEBACK) begin
            rf_wr_en = 1'b1;
            if (opcode == LOAD) begin
                rf_wr_data = rd_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            stage <= FETCH_START;
            wr_en <= 1'b0;
        end else begin
            wr_en <= (stage == EXECUTE) && (opcode == STORE);
            case (stage)
                FETCH_START: stage <= FETCH_HI;
                FETCH_HI:    stage <= FETCH_LO;
                FETCH_LO:    stage <= EXECUTE;
                EXECUTE: begin
                    if (is_arith || opcode == LOAD) begin
                        stage <= WRITEBACK;
                    end else if (opcode == STORE) begin
                        stage <= STORE_STAGE;
                    end else begin
                        stage <= FETCH_START;
                    end
                end
                default:     stage <= FETCH_START;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (stage)
            FETCH_HI: begin
                ir[15:8] <= rd_data;
            end
            FETCH_LO: begin
                ir[7:0] <= rd_data;
                // Register-register forms read ra and everything else reads rd
                if (opcode == ADDRR || opcode == SUBRR) begin
                    rd0_addr <= rd_data[7:4];
                end else begin
                    rd0_addr <= ir[11:8];
                end
                rd1_addr <= rd_data[3:0];
            end
            EXECUTE: begin
                if (opcode == STORE) begin
                    wr_addr <= ir[7:0];
                    wr_data <= rd0_data;
                end
            end
            default: begin
            end
        endcase
    end

    alu u_alu (
        .clk        (clk),
        .reset_n    (reset_n),
        .a          (rd0_data),
        .b          (alu_b),
        .subtract   (subtract),
        .flag_we    (flag_we),
        .result     (alu_result),
        .zero_flag  (zero_flag),
        .carry_flag ()
    );

    register_file u_register_file (
        .clk      (clk),
        .reset_n  (reset_n),
        .rd0_addr (rd0_addr),
        .rd1_addr (rd1_addr),
        .wr_en    (rf_wr_en),
        .wr_addr  (ir[11:8]),
        .wr_data  (rf_wr_data),
        .rd0_data (rd0_data),
        .rd1_data (rd1_data)
    );

    pc_sequencer u_pc_sequencer (
        .clk              (clk),
        .reset_n          (reset_n),
        .boundary         (boundary),
        .pc_sel           (pc_sel),
        .jump_target      (rd_data),
        .int_req          (int_req),
        .int_enable_set   (int_enable_set),
        .int_enable_clear (int_enable_clear),
        .pc               (pc),
        .take_interrupt   (take_interrupt),
        .int_ack          (int_ack)
    );

    store_in_store_stage: assert property (
        @(posedge clk) disable iff (!reset_n) wr_en |-> stage == STORE_STAGE
    );

    no_read_unless_load: assert property (
        @(posedge clk) disable iff (!reset_n)
        (stage == EXECUTE && opcode != LOAD) |-> !rd_en
    );

endmodule

// File: unified_ram.sv
`timescale 1ns/1ps

module unified_ram (
    input  logic                         clk,
    input  logic                         rd_en,
    input  logic [cpu_pkg::addr_bits-1:0] rd_addr,
    output logic [cpu_pkg::data_bits-1:0] rd_data,
    input  logic                         wr_en,
    input  logic [cpu_pkg::addr_bits-1:0] wr_addr,
    input  logic [cpu_pkg::data_bits-1:0] wr_data,
    input  logic                         load_en,
    input  logic [cpu_pkg::addr_bits-1:0] load_addr,
    input  logic [cpu_pkg::data_bits-1:0] load_data
);
    import cpu_pkg::*;

    logic [data_bits-1:0] mem [2**addr_bits];

    // Load port wins over a CPU store in the same cycle
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         int_req,
    output logic                         int_ack,
    input  logic                         load_en,
    input  logic [cpu_pkg::addr_bits-1:0] load_addr,
    input  logic [cpu_pkg::data_bits-1:0] load_data,
    output logic                         mem_wr_en,
    output logic [cpu_pkg::addr_bits-1:0] mem_wr_addr,
    output logic [cpu_pkg::data_bits-1:0] mem_wr_data
);
    import cpu_pkg::*;

    logic                 cpu_rd_en;
    logic [addr_bits-1:0] cpu_rd_addr;
    logic [data_bits-1:0] cpu_rd_data;

    // CPU write bus doubles as the store monitor
    exec_unit u_exec_unit (
        .clk     (clk),
        .reset_n (reset_n),
        .rd_en   (cpu_rd_en),
        .rd_addr (cpu_rd_addr),
        .rd_data (cpu_rd_data),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (mem_wr_data),
        .int_req (int_req),
        .int_ack (int_ack)
    );

    unified_ram u_unified_ram (
        .clk       (clk),
        .rd_en     (cpu_rd_en),
        .rd_addr   (cpu_rd_addr),
        .rd_data   (cpu_rd_data),
        .wr_en     (mem_wr_en),
        .wr_addr   (mem_wr_addr),
        .wr_data   (mem_wr_data),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

// File: tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    logic                 clk;
    logic                 reset_n;
    logic                 int_req;
    logic                 int_ack;
    logic                 load_en;
    logic [addr_bits-1:0] load_addr;
    logic [data_bits-1:0] load_data;
    logic                 mem_wr_en;
    logic [addr_bits-1:0] mem_wr_addr;
    logic [data_bits-1:0] mem_wr_data;

    logic [7:0]  image [256];
    bit          loaded [256];
    logic [7:0]  asm_pc;
    logic [31:0] rng;
    logic [15:0] exp_stores [32];
    string       exp_name [32];
    int          exp_count = 0;
    int          store_idx = 0;
    int          ready_idx = 0;
    int          cli_idx = 0;
    int          errors = 0;
    int          timeouts = 0;
    logic        ack_allowed;
    logic [15:0] exp_head;
    logic        exp_valid;

    cpu_top uut (
        .clk         (clk),
        .reset_n     (reset_n),
        .int_req     (int_req),
        .int_ack     (int_ack),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    assign exp_valid = store_idx < exp_count;
    assign exp_head = exp_stores[store_idx];

    always @(posedge clk) begin
        if (reset_n && mem_wr_en) begin
            store_idx <= store_idx + 1;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] random_byte();
        rng = xorshift(rng);
        return rng[7:0];
    endfunction

    task automatic show_mismatch(input int idx, input logic [15:0] actual);
        errors++;
        if (idx >= exp_count) begin
            $display("Unexpected store to %h with data %h after the last expected store",
                     actual[15:8], actual[7:0]);
        end else begin
            $display("MISMATCH %s: expected addr %h data %h, actual addr %h data %h",
                     exp_name[idx], exp_stores[idx][15:8], exp_stores[idx][7:0],
                     actual[15:8], actual[7:0]);
        end
    endtask

    task automatic count_failure(input string what);
        errors++;
        $display("%s", what);
    endtask

    // Every store must match the head of the expected list
    store_check: assert property (
        @(posedge clk) disable iff (!reset_n)
        mem_wr_en |-> exp_valid && (exp_head == {mem_wr_addr, mem_wr_data})
    ) else show_mismatch($sampled(store_idx), $sampled({mem_wr_addr, mem_wr_data}));

    ack_check: assert property (
        @(posedge clk) disable iff (!reset_n) int_ack |-> ack_allowed
    ) else count_failure("int_ack was raised while no interrupt should be taken");

    known_check: assert property (
        @(posedge clk) disable iff (!reset_n) !$isunknown({mem_wr_en, int_ack})
    ) else count_failure("mem_wr_en or int_ack is unknown after reset");

    task automatic emit(input opcode_t op, input logic [3:0] rd, input logic [7:0] low);
        image[asm_pc] = {op, rd};
        image[asm_pc + 8'd1] = low;
        loaded[asm_pc] = 1'b1;
        loaded[asm_pc + 8'd1] = 1'b1;
        asm_pc = asm_pc + 8'd2;
    endtask

    task automatic expect_store(input string name, input logic [7:0] addr,
                                input logic [7:0] data);
        exp_stores[exp_count] = {addr, data};
        exp_name[exp_count] = name;
        exp_count++;
    endtask

    task automatic build_program();
        logic [7:0] v1;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] c;
        logic [7:0] d;
        logic [7:0] e;
        logic [7:0] k;
        logic [7:0] p;
        logic [7:0] loop_addr;
        int         n;
        v1 = random_byte();
        a = random_byte();
        b = random_byte();
        c = random_byte();
        d = random_byte();
        e = random_byte();
        k = random_byte();
        p = random_byte();
        n = int'(random_byte() % 8) + 1;
        asm_pc = 8'h00;
        emit(MOVIR, 4'd1, v1);
        emit(STORE, 4'd1, 8'h80);
        expect_store("movir_store", 8'h80, v1);
        emit(MOVIR, 4'd2, a);
        emit(MOVIR, 4'd3, b);
        emit(MOVIR, 4'd7, 8'h11);
        emit(MOVIR, 4'd8, 8'h22);
        emit(ADDRR, 4'd4, 8'h23);
        emit(STORE, 4'd4, 8'h81);
        expect_store("addrr", 8'h81, a + b);
        emit(ADDI, 4'd4, c);
        emit(STORE, 4'd4, 8'h82);
        expect_store("addi", 8'h82, a + b + c);
        emit(SUBRR, 4'd5, 8'h23);
        emit(STORE, 4'd5, 8'h83);
        expect_store("subrr", 8'h83, a - b);
        emit(SUBI, 4'd5, d);
        emit(STORE, 4'd5, 8'h84);
        expect_store("subi", 8'h84, a - b - d);
        // e plus its negation wraps to zero, so the JNZI must fall through
        emit(MOVIR, 4'd6, e);
        emit(ADDI, 4'd6, 8'h00 - e);
        emit(STORE, 4'd6, 8'h85);
        expect_store("wrap_zero", 8'h85, e + (8'h00 - e));
        emit(JNZI, 4'd0, asm_pc + 8'd4);
        emit(STORE, 4'd7, 8'h86);
        expect_store("jnzi_fall", 8'h86, 8'h11);
        emit(STORE, 4'd8, 8'h87);
        expect_store("jnzi_fall", 8'h87, 8'h22);
        emit(MOVIR, 4'd9, 8'(n));
        loop_addr = asm_pc;
        emit(SUBI, 4'd9, 8'h01);
        emit(STORE, 4'd9, 8'h88);
        emit(JNZI, 4'd0, loop_addr);
        for (int i = n - 1; i >= 0; i--) begin
            expect_store("jnzi_loop", 8'h88, 8'(i));
        end
        emit(STORE, 4'd7, 8'h89);
        expect_store("loop_end", 8'h89, 8'h11);
        image[8'hc0] = p;
        loaded[8'hc0] = 1'b1;
        emit(LOAD, 4'd10, 8'hc0);
        emit(ADDI, 4'd10, k);
        emit(STORE, 4'd10, 8'h8a);
        expect_store("load", 8'h8a, p + k);
        emit(MOVIR, 4'd13, 8'h01);
        emit(STI, 4'd0, 8'h00);
        emit(STORE, 4'd7, 8'h8b);
        expect_store("int_ready", 8'h8b, 8'h11);
        ready_idx = exp_count;
        // Spin until the ISR clears r13
        loop_addr = asm_pc;
        emit(ADDI, 4'd13, 8'h00);
        emit(JNZI, 4'd0, loop_addr);
        expect_store("isr_marker", 8'hf0, 8'h5a);
        emit(STORE, 4'd7, 8'h8c);
        expect_store("int_return", 8'h8c, 8'h11);
        emit(CLI, 4'd0, 8'h00);
        emit(STORE, 4'd8, 8'h8d);
        expect_store("int_disabled", 8'h8d, 8'h22);
        cli_idx = exp_count;
        emit(MOVIR, 4'd12, 8'd24);
        loop_addr = asm_pc;
        emit(SUBI, 4'd12, 8'h01);
        emit(JNZI, 4'd0, loop_addr);
        emit(STORE, 4'd7, 8'h8e);
        expect_store("final", 8'h8e, 8'h11);
        // Park on a self jump with the zero flag clear
        emit(ADDI, 4'd7, 8'h00);
        emit(JNZI, 4'd0, asm_pc);
        asm_pc = isr_address;
        emit(MOVIR, 4'd13, 8'h00);
        emit(MOVIR, 4'd15, 8'h5a);
        emit(STORE, 4'd15, 8'hf0);
        emit(RETI, 4'd0, 8'h00);
    endtask

    task automatic load_program();
        for (int a = 0; a < 256; a++) begin
            if (loaded[a]) begin
                @(posedge clk);
                #5;
                load_en = 1'b1;
                load_addr = 8'(a);
                load_data = image[a];
            end
        end
        @(posedge clk);
        #5;
        load_en = 1'b0;
    endtask

    task automatic wait_for_stores(input int count, input int limit, output bit ok);
        int cycles;
        cycles = 0;
        while (store_idx < count && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        ok = (store_idx >= count);
        if (!ok) begin
            timeouts++;
            $display("Timeout: only %0d of %0d stores seen after %0d cycles",
                     store_idx, count, limit);
        end
    endtask

    task automatic wait_for_ack(input int limit, output bit ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (!ok && cycles < limit) begin
            @(negedge clk);
            ok = (int_ack === 1'b1);
            cycles++;
        end
        if (!ok) begin
            timeouts++;
            $display("Timeout: no int_ack within %0d cycles of the interrupt request", limit);
        end
    endtask

    task automatic run_sequence();
        bit ok;
        wait_for_stores(ready_idx, 2000, ok);
        if (!ok) return;
        @(posedge clk);
        #5;
        ack_allowed = 1'b1;
        int_req = 1'b1;
        wait_for_ack(200, ok);
        if (!ok) return;
        @(posedge clk);
        #5;
        ack_allowed = 1'b0;
        int_req = 1'b0;
        wait_for_stores(cli_idx, 1000, ok);
        if (!ok) return;
        // Second edge arrives with interrupts disabled
        @(posedge clk);
        #5;
        int_req = 1'b1;
        wait_for_stores(exp_count, 2000, ok);
        if (!ok) return;
        repeat (40) @(posedge clk);
    endtask

    initial begin
        reset_n = 1'b0;
        int_req = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        ack_allowed = 1'b0;
        rng = 32'he210;
        build_program();
        load_program();
        repeat (16) @(posedge clk);
        #5;
        reset_n = 1'b1;
        run_sequence();
        $display("Summary: %0d errors, %0d timeouts, %0d of %0d stores checked",
                 errors, timeouts, store_idx, exp_count);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: list.f
cpu_pkg.sv
alu.sv
register_file.sv
pc_sequencer.sv
exec_unit.sv
unified_ram.sv
cpu_top.sv
tb_cpu.sv
